// ==== dv/detection_checker.sv ====
`timescale 1ns/10ps

module detection_checker #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                         clk_os,
	input  logic                         i_rst_n,
	input  logic                         i_pix_valid,
	input  logic                         i_pix_ready,
	input  logic [haar_pkg::PIXEL_W-1:0] i_pix_data,
	input  logic                         i_win_valid,
	input  logic                         i_win_ready,
	input  logic [haar_pkg::COORD_W:0]   i_win_x,
	input  logic [haar_pkg::COORD_W:0]   i_win_y,
	input  logic                         i_win_face,
	output int                           o_err_count,
	output int                           o_result_count
);
	import haar_pkg::*;

	localparam int RW   = FRAME_W / 2;
	localparam int RH   = FRAME_H / 2;
	localparam int NWIN = (RW - WIN_SIZE + 1) * (RH - WIN_SIZE + 1);

	typedef struct packed {
		logic [3:0]       frame;
		logic [COORD_W:0] x;
		logic [COORD_W:0] y;
		logic             face;
	} win_result_t;

	int          pix [FRAME_H][FRAME_W];
	int          ii_ref [RH+1][RW+1]; // padded integral, row 0 and column 0 stay zero.
	win_result_t exp_q [$];
	int          pix_cnt = 0;
	int          frames_in = 0;
	int          early_pix = 0; // pixels of the next frame taken while results are owed.
	int          seen = 0;
	int          faces = 0;
	int          err_count = 0;
	int          result_count = 0;
	logic        idle_checked = 1'b0;

	assign o_err_count = err_count;
	assign o_result_count = result_count;

	function automatic string test_name(int frame);
		case (frame)
			0: return "random_1";
			1: return "random_2";
			2: return "constant";
			3: return "bright_top";
			default: return "pattern";
		endcase
	endfunction

	function automatic int rect_sum(int x0, int y0, int w, int h);
		return ii_ref[y0+h][x0+w] - ii_ref[y0][x0+w] - ii_ref[y0+h][x0] + ii_ref[y0][x0];
	endfunction

	function automatic int rect_term(haar_rect_t r, int wx, int wy);
		return $signed(r.weight) * rect_sum(wx + int'(r.x), wy + int'(r.y), int'(r.w), int'(r.h));
	endfunction

	// walks the cascade for one window and returns 1 for a face.
	function automatic int window_face(int wx, int wy);
		haar_word_u wd;
		int         fv;
		int         sum;
		int         a;
		sum = 0;
		for (a = 0; a < DB_DEPTH; a++)
		begin
			wd = HAAR_ROM[a];
			if (wd.feat.tag == 1'b0)
			begin
				fv = rect_term(wd.feat.r0, wx, wy) + rect_term(wd.feat.r1, wx, wy);
				if (fv < $signed(wd.feat.thr))
					sum += $signed(wd.feat.left_val);
				else
					sum += $signed(wd.feat.right_val);
			end
			else if (sum < $signed(wd.stage.thr))
				return 0; // a failed stage ends the window.
			else if (wd.stage.last)
				return 1;
			else
				sum = 0;
		end
		return 0;
	endfunction

	task automatic build_expected();
		win_result_t e;
		int          acc;
		int          quad;
		int          rx;
		int          ry;
		for (rx = 0; rx <= RW; rx++)
			ii_ref[0][rx] = 0;
		for (ry = 0; ry < RH; ry++)
		begin
			acc = 0;
			ii_ref[ry+1][0] = 0;
			for (rx = 0; rx < RW; rx++)
			begin
				quad = pix[2*ry][2*rx] + pix[2*ry][2*rx+1];
				quad += pix[2*ry+1][2*rx] + pix[2*ry+1][2*rx+1];
				acc += quad / 4; // floor of the 2x2 average.
				ii_ref[ry+1][rx+1] = ii_ref[ry][rx+1] + acc;
			end
		end
		for (ry = 0; ry <= RH - WIN_SIZE; ry++)
			for (rx = 0; rx <= RW - WIN_SIZE; rx++)
			begin
				e.frame = 4'(frames_in);
				e.x = (COORD_W+1)'(2 * rx);
				e.y = (COORD_W+1)'(2 * ry);
				e.face = 1'(window_face(rx, ry));
				exp_q.push_back(e);
			end
	endtask

	task automatic take_pixel();
		if (exp_q.size() > 0)
		begin
			early_pix++;
			if (early_pix == FRAME_W + 3)
			begin
				$display("[ERROR] test %s: pixels taken before release expected at most %0d, actual %0d",
					test_name(frames_in), FRAME_W + 2, early_pix);
				err_count++;
			end
		end
		pix[pix_cnt / FRAME_W][pix_cnt % FRAME_W] = i_pix_data;
		pix_cnt++;
		if (pix_cnt == FRAME_W * FRAME_H)
		begin
			build_expected();
			pix_cnt = 0;
			frames_in++;
		end
	endtask

	task automatic close_frame(int frame);
		if (frame == 2 && faces != 0 && faces != NWIN)
		begin
			$display("[ERROR] test %s: faces expected 0 or %0d, actual %0d",
				test_name(frame), NWIN, faces);
			err_count++;
		end
		if (frame >= 3 && (faces == 0 || faces == NWIN))
		begin
			$display("[ERROR] test %s: faces expected between 1 and %0d, actual %0d",
				test_name(frame), NWIN - 1, faces);
			err_count++;
		end
	endtask

	task automatic check_result();
		win_result_t e;
		result_count++;
		if (exp_q.size() == 0)
		begin
			$display("A window result at x %0d y %0d arrived when none was expected.",
				i_win_x, i_win_y);
			err_count++;
		end
		else
		begin
			e = exp_q.pop_front();
			if (i_win_x != e.x || i_win_y != e.y)
			begin
				$display("[ERROR] test %s: window expected (%0d,%0d), actual (%0d,%0d)",
					test_name(e.frame), e.x, e.y, i_win_x, i_win_y);
				err_count++;
			end
			if (i_win_face != e.face)
			begin
				$display("[ERROR] test %s: face at (%0d,%0d) expected %0d, actual %0d",
					test_name(e.frame), e.x, e.y, e.face, i_win_face);
				err_count++;
			end
			seen++;
			faces += int'(i_win_face);
			if (seen == NWIN)
			begin
				close_frame(e.frame);
				seen = 0;
				faces = 0;
			end
			if (exp_q.size() == 0)
				early_pix = 0;
		end
	endtask

	always @(posedge clk_os)
	begin
		if (i_rst_n)
		begin
			if (!idle_checked)
			begin
				idle_checked = 1'b1; // first edge out of reset.
				if (i_win_valid !== 1'b0 || i_pix_ready !== 1'b1)
				begin
					$display("[ERROR] test reset_idle: valid/ready expected 0/1, actual %b/%b",
						i_win_valid, i_pix_ready);
					err_count++;
				end
			end
			if (i_pix_valid && i_pix_ready)
				take_pixel();
			if (i_win_valid && i_win_ready)
				check_result();
		end
	end

endmodule

// ==== dv/tb_facial_detection.sv ====
`timescale 1ns/10ps

module tb_facial_detection;
	import haar_pkg::*;

	localparam int FRAME_W    = 16;
	localparam int FRAME_H    = 12;
	localparam int TB_SEED    = 50333;
	localparam int NUM_FRAMES = 5;
	localparam int PER_FRAME  = (FRAME_W / 2 - WIN_SIZE + 1) * (FRAME_H / 2 - WIN_SIZE + 1);
	localparam int WAIT_LIMIT = 20000; // cycles, well above one frame scan.

	logic               clk_os;
	logic               i_rst_n;
	logic               i_pix_valid;
	logic               o_pix_ready;
	logic [PIXEL_W-1:0] i_pix_data;
	logic               o_win_valid;
	logic               i_win_ready;
	logic [COORD_W:0]   o_win_x;
	logic [COORD_W:0]   o_win_y;
	logic               o_win_face;
	int                 err_count;
	int                 result_count;
	int                 timeouts = 0;

	initial
	begin
		clk_os = 1'b0;
		forever
			#2 clk_os = ~clk_os;
	end

	facial_detection_ip facial_detection_ip_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n),
		.i_pix_valid(i_pix_valid), .o_pix_ready(o_pix_ready), .i_pix_data(i_pix_data),
		.o_win_valid(o_win_valid), .i_win_ready(i_win_ready),
		.o_win_x(o_win_x), .o_win_y(o_win_y), .o_win_face(o_win_face)
	);

	detection_checker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) detection_checker_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n),
		.i_pix_valid(i_pix_valid), .i_pix_ready(o_pix_ready), .i_pix_data(i_pix_data),
		.i_win_valid(o_win_valid), .i_win_ready(i_win_ready),
		.i_win_x(o_win_x), .i_win_y(o_win_y), .i_win_face(o_win_face),
		.o_err_count(err_count), .o_result_count(result_count)
	);

	// a bright bar over a dark band on the left half, flat on the right.
	function automatic logic [PIXEL_W-1:0] pattern_pixel(int rx, int ry);
		if (rx >= 4)
			return 8'd100;
		return (ry == 2) ? 8'd240 : 8'd30;
	endfunction

	task automatic offer_pixel(input logic [PIXEL_W-1:0] value);
		int n;
		n = 0;
		if (($urandom % 4) == 0)
		begin
			i_pix_valid = 1'b0; // random gap before this pixel.
			repeat (1 + $urandom % 3) @(negedge clk_os);
		end
		i_pix_valid = 1'b1;
		i_pix_data = value;
		while (!o_pix_ready && n < WAIT_LIMIT)
		begin
			@(negedge clk_os);
			n++;
		end
		if (!o_pix_ready)
		begin
			$display("Timed out after %0d cycles waiting for the DUT to take a pixel.", n);
			timeouts++;
		end
		@(negedge clk_os); // taken on the rising edge just passed.
	endtask

	task automatic stream_frame(input int frame);
		logic [PIXEL_W-1:0] v;
		int                 r;
		int                 c;
		for (r = 0; r < FRAME_H && timeouts == 0; r++)
			for (c = 0; c < FRAME_W && timeouts == 0; c++)
			begin
				case (frame)
					0, 1: v = PIXEL_W'($urandom % 256);
					2: v = 8'd90;
					3: v = (r < FRAME_H / 2) ? 8'd200 : 8'd20;
					default: v = pattern_pixel(c / 2, r / 2);
				endcase
				offer_pixel(v);
			end
		i_pix_valid = 1'b0;
	endtask

	task automatic wait_results(input int target);
		int n;
		n = 0;
		while (result_count < target && n < WAIT_LIMIT)
		begin
			@(negedge clk_os);
			n++;
		end
		if (result_count < target)
		begin
			$display("Timed out waiting for window results, %0d of %0d arrived.",
				result_count, target);
			timeouts++;
		end
	endtask

	task automatic drive_win_ready();
		forever
		begin
			@(negedge clk_os);
			i_win_ready = (($urandom % 3) != 0); // low about one cycle in three.
		end
	endtask

	initial
	begin
		int f;
		void'($urandom(TB_SEED));
		i_rst_n = 1'b0;
		i_pix_valid = 1'b0;
		i_pix_data = '0;
		i_win_ready = 1'b0;
		repeat (10) @(negedge clk_os);
		i_rst_n = 1'b1;
		repeat (3) @(negedge clk_os);
		fork
			drive_win_ready();
		join_none
		for (f = 0; f < NUM_FRAMES && timeouts == 0; f++)
		begin
			stream_frame(f);
			if (f > 0 && timeouts == 0)
				wait_results(f * PER_FRAME); // the previous frame is finished.
		end
		if (timeouts == 0)
			wait_results(NUM_FRAMES * PER_FRAME);
		repeat (20) @(negedge clk_os); // any extra result shows up here.
		$display("Run summary: %0d results, %0d check errors, %0d timeouts.",
			result_count, err_count, timeouts);
		if (err_count == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== rtl/detect_ctrl.sv ====
`timescale 1ns/10ps

module detect_ctrl #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                       clk_os,
	input  logic                       i_rst_n,
	input  logic                       i_frame_full,
	output logic                       o_frame_release,
	db_rd_if.client                    db,
	feat_if.ctrl                       feat,
	output logic                       o_win_valid,
	input  logic                       i_win_ready,
	output logic [haar_pkg::COORD_W:0] o_win_x,
	output logic [haar_pkg::COORD_W:0] o_win_y,
	output logic                       o_win_face
);
	import haar_pkg::*;

	localparam int RW     = FRAME_W / 2;
	localparam int RH     = FRAME_H / 2;
	localparam int LAST_X = RW - WIN_SIZE;
	localparam int LAST_Y = RH - WIN_SIZE;

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_DECODE, S_REQ, S_RES, S_OUT, S_REL
	} state_t;

	state_t                  state;
	logic [COORD_W-1:0]      wx;
	logic [COORD_W-1:0]      wy;
	logic [DB_AW-1:0]        addr;
	logic signed [SUM_W-1:0] stage_sum;
	haar_feature_t           feat_q;
	logic                    last_win;

	assign db.rd_en = (state == S_FETCH);
	assign db.addr = addr;
	assign feat.req_valid = (state == S_REQ);
	assign feat.feature = feat_q;
	assign feat.win_x = wx;
	assign feat.win_y = wy;
	assign o_win_valid = (state == S_OUT);
	assign o_win_x = {wx, 1'b0}; // back to original-frame pixels.
	assign o_win_y = {wy, 1'b0};
	assign o_frame_release = (state == S_REL);
	assign last_win = (wx == COORD_W'(LAST_X)) && (wy == COORD_W'(LAST_Y));

	always_ff @(posedge clk_os or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= S_IDLE;
			wx <= '0;
			wy <= '0;
			addr <= '0;
			stage_sum <= '0;
			o_win_face <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (i_frame_full)
					begin
						wx <= '0;
						wy <= '0;
						addr <= '0;
						stage_sum <= '0;
						state <= S_FETCH;
					end
				S_FETCH:
					state <= S_DECODE;
				S_DECODE:
					if (db.word_valid)
					begin
						if (!db.word.feat.tag)
							state <= S_REQ;
						else if (stage_sum < db.word.stage.thr)
						begin
							o_win_face <= 1'b0; // early exit on a failed stage.
							state <= S_OUT;
						end
						else if (db.word.stage.last)
						begin
							o_win_face <= 1'b1;
							state <= S_OUT;
						end
						else
						begin
							stage_sum <= '0;
							addr <= addr + 1'b1;
							state <= S_FETCH;
						end
					end
				S_REQ:
					if (feat.req_ready)
						state <= S_RES;
				S_RES:
					if (feat.res_valid)
					begin
						stage_sum <= stage_sum + feat.res_value;
						addr <= addr + 1'b1;
						state <= S_FETCH;
					end
				S_OUT:
					if (i_win_ready)
					begin
						addr <= '0;
						stage_sum <= '0;
						if (last_win)
							state <= S_REL;
						else
						begin
							state <= S_FETCH;
							if (wx == COORD_W'(LAST_X))
							begin
								wx <= '0;
								wy <= wy + 1'b1;
							end
							else
								wx <= wx + 1'b1;
						end
					end
				default:
					state <= S_IDLE; // the release cycle frees the builder.
			endcase
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (state == S_DECODE && db.word_valid)
			feat_q <= db.word.feat;
	end

endmodule

// ==== rtl/facial_detection_ip.sv ====
`timescale 1ns/10ps

module facial_detection_ip #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                         clk_os,
	input  logic                         i_rst_n,
	input  logic                         i_pix_valid,
	output logic                         o_pix_ready,
	input  logic [haar_pkg::PIXEL_W-1:0] i_pix_data,
	output logic                         o_win_valid,
	input  logic                         i_win_ready,
	output logic [haar_pkg::COORD_W:0]   o_win_x,
	output logic [haar_pkg::COORD_W:0]   o_win_y,
	output logic                         o_win_face
);
	import haar_pkg::*;

	logic               rs_valid;
	logic               rs_ready;
	logic [PIXEL_W-1:0] rs_pixel;
	logic               frame_full;
	logic               frame_release;

	db_rd_if db ();
	ii_rd_if ii ();
	feat_if  feat ();

	frame_resizer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) frame_resizer_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n),
		.i_pix_valid(i_pix_valid), .o_pix_ready(o_pix_ready), .i_pix_data(i_pix_data),
		.o_rs_valid(rs_valid), .i_rs_ready(rs_ready), .o_rs_pixel(rs_pixel)
	);

	integral_builder #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) integral_builder_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n),
		.i_rs_valid(rs_valid), .o_rs_ready(rs_ready), .i_rs_pixel(rs_pixel),
		.o_frame_full(frame_full), .i_frame_release(frame_release), .ii(ii.server)
	);

	haar_database haar_database_inst (.clk_os(clk_os), .i_rst_n(i_rst_n), .db(db.server));

	feature_evaluator feature_evaluator_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n), .feat(feat.evaluator), .ii(ii.client)
	);

	detect_ctrl #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) detect_ctrl_inst (
		.clk_os(clk_os), .i_rst_n(i_rst_n),
		.i_frame_full(frame_full), .o_frame_release(frame_release),
		.db(db.client), .feat(feat.ctrl),
		.o_win_valid(o_win_valid), .i_win_ready(i_win_ready),
		.o_win_x(o_win_x), .o_win_y(o_win_y), .o_win_face(o_win_face)
	);

endmodule

// ==== rtl/feature_evaluator.sv ====
`timescale 1ns/10ps

module feature_evaluator (
	input  logic        clk_os,
	input  logic        i_rst_n,
	feat_if.evaluator   feat,
	ii_rd_if.client     ii
);
	import haar_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_DONE} state_t;

	state_t                  state;
	haar_feature_t           feat_q;
	logic [COORD_W-1:0]      wx_q;
	logic [COORD_W-1:0]      wy_q;
	logic [2:0]              rd_idx; // rectangle in bit 2, corner in bits 1:0.
	logic [2:0]              ret_idx;
	haar_rect_t              rd_rect;
	haar_rect_t              ret_rect;
	logic signed [3:0]       ret_weight;
	logic signed [II_W+1:0]  corner_val;
	logic signed [II_W+1:0]  rect_acc;
	logic signed [II_W+1:0]  rect_sum;
	logic signed [II_W+5:0]  feat_sum;

	assign feat.req_ready = (state == S_IDLE);
	assign ii.rd_en = (state == S_ISSUE);

	// corners A, B, C and D in that order, B and D to the right, C and D below.
	assign rd_rect = rd_idx[2] ? feat_q.r1 : feat_q.r0;
	assign ii.cx = wx_q + COORD_W'(rd_rect.x) + (rd_idx[0] ? COORD_W'(rd_rect.w) : '0);
	assign ii.cy = wy_q + COORD_W'(rd_rect.y) + (rd_idx[1] ? COORD_W'(rd_rect.h) : '0);

	assign ret_rect = ret_idx[2] ? feat_q.r1 : feat_q.r0;
	assign ret_weight = ret_rect.weight;
	assign corner_val = (ret_idx[0] ^ ret_idx[1]) ? -$signed({2'b00, ii.data})
		: $signed({2'b00, ii.data}); // B and C are subtracted.
	assign rect_sum = rect_acc + corner_val;

	always_ff @(posedge clk_os or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= S_IDLE;
			rd_idx <= '0;
			ret_idx <= '0;
			feat.res_valid <= 1'b0;
		end
		else
		begin
			feat.res_valid <= 1'b0;
			if (ii.data_valid)
				ret_idx <= ret_idx + 1'b1;
			case (state)
				S_IDLE:
					if (feat.req_valid)
						state <= S_ISSUE;
				S_ISSUE:
				begin
					rd_idx <= rd_idx + 1'b1;
					if (rd_idx == 3'd7)
						state <= S_WAIT;
				end
				S_WAIT:
					if (ii.data_valid && ret_idx == 3'd7)
						state <= S_DONE;
				default:
				begin
					feat.res_valid <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (feat.req_valid && feat.req_ready)
		begin
			feat_q <= feat.feature;
			wx_q <= feat.win_x;
			wy_q <= feat.win_y;
			rect_acc <= '0;
			feat_sum <= '0;
		end
		else if (ii.data_valid)
		begin
			if (ret_idx[1:0] == 2'd3)
			begin
				feat_sum <= feat_sum + rect_sum * ret_weight; // rectangle complete.
				rect_acc <= '0;
			end
			else
				rect_acc <= rect_sum;
		end
		if (state == S_DONE)
			feat.res_value <= (feat_sum < $signed(feat_q.thr)) ? feat_q.left_val
				: feat_q.right_val;
	end

endmodule

// ==== rtl/frame_resizer.sv ====
`timescale 1ns/10ps

module frame_resizer #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                         clk_os,
	input  logic                         i_rst_n,
	input  logic                         i_pix_valid,
	output logic                         o_pix_ready,
	input  logic [haar_pkg::PIXEL_W-1:0] i_pix_data,
	output logic                         o_rs_valid,
	input  logic                         i_rs_ready,
	output logic [haar_pkg::PIXEL_W-1:0] o_rs_pixel
);
	import haar_pkg::*;

	localparam int RW = FRAME_W / 2;
	localparam int CW = $clog2(FRAME_W);
	localparam int HW = $clog2(FRAME_H);

	logic [CW-1:0]      col;
	logic [HW-1:0]      row;
	logic [PIXEL_W-1:0] even_pix;
	logic [PIXEL_W:0]   line_buf [RW]; // pair sums of the last even row.
	logic [PIXEL_W:0]   pair_sum;
	logic [PIXEL_W+1:0] quad_sum;
	logic               xfer;

	assign o_pix_ready = !o_rs_valid || i_rs_ready; // stall while the output is held.
	assign xfer = i_pix_valid && o_pix_ready;
	assign pair_sum = {1'b0, even_pix} + {1'b0, i_pix_data};
	assign quad_sum = {1'b0, pair_sum} + {1'b0, line_buf[col[CW-1:1]]};

	always_ff @(posedge clk_os or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			col <= '0;
			row <= '0;
			o_rs_valid <= 1'b0;
		end
		else
		begin
			if (xfer)
			begin
				if (col == CW'(FRAME_W - 1))
				begin
					col <= '0;
					row <= (row == HW'(FRAME_H - 1)) ? '0 : row + 1'b1;
				end
				else
					col <= col + 1'b1;
			end
			if (xfer && col[0] && row[0])
				o_rs_valid <= 1'b1; // bottom right pixel of a 2x2 block.
			else if (i_rs_ready)
				o_rs_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (xfer && !col[0])
			even_pix <= i_pix_data;
		if (xfer && col[0] && !row[0])
			line_buf[col[CW-1:1]] <= pair_sum;
		if (xfer && col[0] && row[0])
			o_rs_pixel <= quad_sum[PIXEL_W+1:2]; // floor of the 2x2 average.
	end

endmodule

// ==== rtl/haar_database.sv ====
`timescale 1ns/10ps

module haar_database (
	input  logic    clk_os,
	input  logic    i_rst_n,
	db_rd_if.server db
);
	import haar_pkg::*;

	always_ff @(posedge clk_os or negedge i_rst_n)
	begin
		if (!i_rst_n)
			db.word_valid <= 1'b0;
		else
			db.word_valid <= db.rd_en;
	end

	always_ff @(posedge clk_os)
	begin
		if (db.rd_en)
			db.word <= (db.addr < DB_AW'(DB_DEPTH)) ? HAAR_ROM[db.addr] : '0;
	end

endmodule

// ==== rtl/haar_ifs.sv ====
`timescale 1ns/10ps

interface db_rd_if;
	import haar_pkg::*;

	logic             rd_en;
	logic [DB_AW-1:0] addr;
	haar_word_u       word; // valid one cycle after rd_en.
	logic             word_valid;

	modport client (output rd_en, output addr, input word, input word_valid);
	modport server (input rd_en, input addr, output word, output word_valid);
endinterface

interface ii_rd_if;
	import haar_pkg::*;

	logic               rd_en;
	logic [COORD_W-1:0] cx; // padded coordinates, 0 is the zero border.
	logic [COORD_W-1:0] cy;
	logic [II_W-1:0]    data;
	logic               data_valid;

	modport client (output rd_en, output cx, output cy, input data, input data_valid);
	modport server (input rd_en, input cx, input cy, output data, output data_valid);
endinterface

interface feat_if;
	import haar_pkg::*;

	logic                    req_valid;
	logic                    req_ready;
	haar_feature_t           feature;
	logic [COORD_W-1:0]      win_x; // window origin in resized pixels.
	logic [COORD_W-1:0]      win_y;
	logic                    res_valid; // single-cycle pulse.
	logic signed [VAL_W-1:0] res_value;

	modport ctrl (output req_valid, output feature, output win_x, output win_y,
		input req_ready, input res_valid, input res_value);
	modport evaluator (input req_valid, input feature, input win_x, input win_y,
		output req_ready, output res_valid, output res_value);
endinterface

// ==== rtl/haar_pkg.sv ====
package haar_pkg;

	localparam int PIXEL_W  = 8;
	localparam int II_W     = 20; // covers a resized frame of up to 64x64.
	localparam int WIN_SIZE = 4;
	localparam int DB_DEPTH = 7;
	localparam int DB_AW    = 3;
	localparam int COORD_W  = 7; // padded corner coordinates up to 64.
	localparam int VAL_W    = 12; // width of a feature left or right value.
	localparam int SUM_W    = 14; // width of a stage sum and its threshold.

	typedef struct packed {
		logic [1:0]        x;
		logic [1:0]        y;
		logic [2:0]        w; // 1 to 4 pixels.
		logic [2:0]        h;
		logic signed [3:0] weight;
	} haar_rect_t;

	typedef struct packed {
		logic                    tag; // 0 marks a feature record.
		haar_rect_t              r0;
		haar_rect_t              r1;
		logic signed [15:0]      thr;
		logic signed [VAL_W-1:0] left_val;
		logic signed [VAL_W-1:0] right_val;
	} haar_feature_t;

	typedef struct packed {
		logic                                    tag; // 1 marks a stage record.
		logic                                    last;
		logic [$bits(haar_feature_t)-SUM_W-3:0]  rsvd;
		logic signed [SUM_W-1:0]                 thr;
	} haar_stage_t;

	typedef union packed {
		haar_feature_t feat;
		haar_stage_t   stage;
	} haar_word_u;

	function automatic haar_rect_t mk_rect(int x, int y, int w, int h, int wt);
		haar_rect_t r;
		r.x = 2'(x);
		r.y = 2'(y);
		r.w = 3'(w);
		r.h = 3'(h);
		r.weight = 4'(wt);
		return r;
	endfunction

	function automatic haar_word_u mk_feat(haar_rect_t ra, haar_rect_t rb, int t, int lv, int rv);
		haar_word_u wd;
		wd.feat.tag = 1'b0;
		wd.feat.r0 = ra;
		wd.feat.r1 = rb;
		wd.feat.thr = 16'(t);
		wd.feat.left_val = VAL_W'(lv);
		wd.feat.right_val = VAL_W'(rv);
		return wd;
	endfunction

	function automatic haar_word_u mk_stage(int t, logic is_last);
		haar_word_u wd;
		wd = '0;
		wd.stage.tag = 1'b1;
		wd.stage.last = is_last;
		wd.stage.thr = SUM_W'(t);
		return wd;
	endfunction

	// Every feature is balanced, so a flat window gives a zero feature value.
	localparam haar_word_u HAAR_ROM [DB_DEPTH] = '{
		mk_feat(mk_rect(0, 0, 4, 4, -1), mk_rect(0, 0, 4, 2, 2), 200, -3, 5),
		mk_feat(mk_rect(0, 0, 4, 4, -1), mk_rect(0, 0, 2, 4, 2), -300, -4, 1),
		mk_stage(2, 1'b0),
		mk_feat(mk_rect(0, 0, 4, 1, 2), mk_rect(0, 1, 4, 1, -2), 100, -2, 3),
		mk_feat(mk_rect(1, 0, 2, 4, 2), mk_rect(0, 0, 4, 4, -1), -200, -1, 2),
		mk_feat(mk_rect(0, 2, 4, 1, 1), mk_rect(0, 3, 4, 1, -1), 50, 2, -1),
		mk_stage(3, 1'b1)
	};

endpackage

// ==== rtl/integral_builder.sv ====
`timescale 1ns/10ps

module integral_builder #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic                         clk_os,
	input  logic                         i_rst_n,
	input  logic                         i_rs_valid,
	output logic                         o_rs_ready,
	input  logic [haar_pkg::PIXEL_W-1:0] i_rs_pixel,
	output logic                         o_frame_full,
	input  logic                         i_frame_release,
	ii_rd_if.server                      ii
);
	import haar_pkg::*;

	localparam int RW    = FRAME_W / 2;
	localparam int RH    = FRAME_H / 2;
	localparam int DEPTH = RW * RH;
	localparam int AW    = $clog2(DEPTH);
	localparam int XW    = $clog2(RW);
	localparam int YW    = $clog2(RH);

	logic [II_W-1:0] mem [DEPTH];
	logic [XW-1:0]   x;
	logic [YW-1:0]   y;
	logic [AW-1:0]   addr;
	logic [II_W-1:0] row_sum; // running sum of the current row.
	logic            wr_pend;
	logic [AW-1:0]   wr_addr;
	logic [AW-1:0]   rd_addr;
	logic            rd_zero;
	logic            rd_zero_q;
	logic [II_W-1:0] rd_q;
	logic [II_W-1:0] rd_val;
	logic            accept;
	logic            last_pend;

	assign last_pend = wr_pend && (wr_addr == AW'(DEPTH - 1));
	assign o_rs_ready = !(o_frame_full || last_pend);
	assign accept = i_rs_valid && o_rs_ready;
	assign rd_val = rd_zero_q ? '0 : rd_q;
	assign ii.data = rd_val;

	// one read port serves the row above while building and the corners once full.
	always_comb
	begin
		if (o_frame_full)
		begin
			rd_zero = (ii.cx == '0) || (ii.cy == '0);
			rd_addr = AW'((ii.cy - 1'b1) * RW + (ii.cx - 1'b1));
		end
		else
		begin
			rd_zero = (y == '0);
			rd_addr = addr - AW'(RW);
		end
	end

	always_ff @(posedge clk_os)
	begin
		rd_q <= mem[rd_addr];
		rd_zero_q <= rd_zero;
		if (wr_pend)
			mem[wr_addr] <= row_sum + rd_val; // row sum plus the integral above.
		if (accept)
		begin
			row_sum <= ((x == '0) ? '0 : row_sum) + II_W'(i_rs_pixel);
			wr_addr <= addr;
		end
	end

	always_ff @(posedge clk_os or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			x <= '0;
			y <= '0;
			addr <= '0;
			wr_pend <= 1'b0;
			o_frame_full <= 1'b0;
			ii.data_valid <= 1'b0;
		end
		else
		begin
			wr_pend <= accept;
			ii.data_valid <= ii.rd_en;
			if (accept)
			begin
				addr <= (addr == AW'(DEPTH - 1)) ? '0 : addr + 1'b1;
				if (x == XW'(RW - 1))
				begin
					x <= '0;
					y <= (y == YW'(RH - 1)) ? '0 : y + 1'b1;
				end
				else
					x <= x + 1'b1;
			end
			if (last_pend)
				o_frame_full <= 1'b1;
			else if (i_frame_release)
				o_frame_full <= 1'b0;
		end
	end

endmodule

// ==== sim.f ====
rtl/haar_pkg.sv
rtl/haar_ifs.sv
rtl/frame_resizer.sv
rtl/integral_builder.sv
rtl/haar_database.sv
rtl/feature_evaluator.sv
rtl/detect_ctrl.sv
rtl/facial_detection_ip.sv
dv/detection_checker.sv
dv/tb_facial_detection.sv
